//--- core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// first fetch address
`define RESET_PC       32'h0000_0000
// trap vector until software writes mtvec
`define MTVEC_RESET    32'h0000_0100

// machine CSR addresses
`define CSR_MSTATUS    12'h300
`define CSR_MTVEC      12'h305
`define CSR_MSCRATCH   12'h340
`define CSR_MEPC       12'h341
`define CSR_MCAUSE     12'h342

`define CAUSE_ECALL_M  32'd11  // environment call from M-mode

`endif

//--- core_pkg.sv
`default_nettype none

package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [2:0]  funct3_t;

  // major opcodes, instr[6:2]
  typedef enum logic [4:0] {
    OP_LOAD   = 5'b00000,
    OP_CALRI  = 5'b00100,
    OP_AUIPC  = 5'b00101,
    OP_STORE  = 5'b01000,
    OP_CALRR  = 5'b01100,
    OP_LUI    = 5'b01101,
    OP_BRANCH = 5'b11000,
    OP_JALR   = 5'b11001,
    OP_JAL    = 5'b11011,
    OP_SYS    = 5'b11100
  } opcode_t;

  localparam funct3_t BR_BEQ  = 3'b000;
  localparam funct3_t BR_BNE  = 3'b001;
  localparam funct3_t BR_BLT  = 3'b100;
  localparam funct3_t BR_BGE  = 3'b101;
  localparam funct3_t BR_BLTU = 3'b110;
  localparam funct3_t BR_BGEU = 3'b111;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASSB
  } alu_op_t;

  // instruction formats, low two bits are always 2'b11 in RV32I
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    funct3_t    funct3;
    reg_idx_t   rd;
    opcode_t    opcode;
    logic [1:0] quad;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    funct3_t     funct3;
    reg_idx_t    rd;
    opcode_t     opcode;
    logic [1:0]  quad;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    funct3_t    funct3;
    logic [4:0] imm_lo;
    opcode_t    opcode;
    logic [1:0] quad;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    funct3_t    funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_t    opcode;
    logic [1:0] quad;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_idx_t    rd;
    opcode_t     opcode;
    logic [1:0]  quad;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    reg_idx_t   rd;
    opcode_t    opcode;
    logic [1:0] quad;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_u;

endpackage

`default_nettype wire

//--- stage_if.sv
`default_nettype none

// fetch -> decode
interface fetch_decode_if import core_pkg::*; ();
  logic  valid;
  logic  ready;
  word_t pc;
  word_t instr;

  modport src (output valid, pc, instr, input ready);
  modport dst (input valid, pc, instr, output ready);
endinterface

// decode -> execute, operands already selected
interface decode_exec_if import core_pkg::*; ();
  logic        valid;
  logic        ready;
  word_t       pc;
  opcode_t     opcode;
  funct3_t     funct3;
  reg_idx_t    rd;
  word_t       src1;
  word_t       src2;
  word_t       imm;
  word_t       csr_rdata;
  logic [11:0] csr_addr;
  word_t       alu_a;
  word_t       alu_b;
  alu_op_t     alu_op;

  modport src (output valid, pc, opcode, funct3, rd, src1, src2, imm, csr_rdata, csr_addr,
               alu_a, alu_b, alu_op, input ready);
  modport dst (input valid, pc, opcode, funct3, rd, src1, src2, imm, csr_rdata, csr_addr,
               alu_a, alu_b, alu_op, output ready);
endinterface

`default_nettype wire

//--- alu.sv
`default_nettype none

module alu import core_pkg::*; (
  input  word_t    alu_a,
  input  word_t    alu_b,
  input  alu_op_t  alu_op,
  output word_t    val
);

  logic [4:0] shamt;

  assign shamt = alu_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:   val = alu_a + alu_b;
      ALU_SUB:   val = alu_a - alu_b;  // zero result means equal
      ALU_SLL:   val = alu_a << shamt;
      ALU_SLT:   val = {31'b0, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU:  val = {31'b0, alu_a < alu_b};
      ALU_XOR:   val = alu_a ^ alu_b;
      ALU_SRL:   val = alu_a >> shamt;
      ALU_SRA:   val = $signed(alu_a) >>> shamt;
      ALU_OR:    val = alu_a | alu_b;
      ALU_AND:   val = alu_a & alu_b;
      ALU_PASSB: val = alu_b;
      default:   val = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- reg_file.sv
`default_nettype none

module reg_file import core_pkg::*; (
  input  wire       clk,
  input  reg_idx_t  rs1,
  input  reg_idx_t  rs2,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  logic      gpr_wen,
  input  reg_idx_t  gpr_waddr,
  input  word_t     gpr_wdata
);

  word_t regs [0:31];

  // x0 may be written but never reads back
  always_ff @(posedge clk) begin
    if (gpr_wen)
      regs[gpr_waddr] <= gpr_wdata;
  end

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- csr_file.sv
`default_nettype none
`include "core_cfg.svh"

module csr_file import core_pkg::*; (
  input  wire          clk,
  input  wire          rstn,
  input  logic [11:0]  csr_raddr,
  output word_t        csr_rdata,
  input  logic         csr_wen1,
  input  logic [11:0]  csr_waddr1,
  input  word_t        csr_wdata1,
  input  logic         csr_wen2,
  input  logic [11:0]  csr_waddr2,
  input  word_t        csr_wdata2
);

  word_t mstatus, mtvec, mepc, mcause, mscratch;

  // next value of one CSR, port 2 has priority
  function automatic word_t upd(logic [11:0] addr, word_t cur);
    upd = cur;
    if (csr_wen1 && csr_waddr1 == addr)
      upd = csr_wdata1;
    if (csr_wen2 && csr_waddr2 == addr)
      upd = csr_wdata2;
  endfunction

  always_ff @(posedge clk) begin
    if (rstn) begin
      mstatus  <= '0;
      mtvec    <= `MTVEC_RESET;
      mepc     <= '0;
      mcause   <= '0;
      mscratch <= '0;
    end else begin
      mstatus  <= upd(`CSR_MSTATUS, mstatus);
      mtvec    <= upd(`CSR_MTVEC, mtvec);
      mepc     <= upd(`CSR_MEPC, mepc);
      mcause   <= upd(`CSR_MCAUSE, mcause);
      mscratch <= upd(`CSR_MSCRATCH, mscratch);
    end
  end

  always_comb begin
    case (csr_raddr)
      `CSR_MSTATUS:  csr_rdata = mstatus;
      `CSR_MTVEC:    csr_rdata = mtvec;
      `CSR_MEPC:     csr_rdata = mepc;
      `CSR_MCAUSE:   csr_rdata = mcause;
      `CSR_MSCRATCH: csr_rdata = mscratch;
      default:       csr_rdata = '0;  // unimplemented
    endcase
  end

endmodule

`default_nettype wire

//--- fetch_stage.sv
`default_nettype none
`include "core_cfg.svh"

module fetch_stage import core_pkg::*; (
  input  wire            clk,
  input  wire            rstn,
  input  logic           npc_valid,
  input  word_t          npc,
  output logic           ibus_cyc,
  output logic           ibus_stb,
  output word_t          ibus_adr,
  input  word_t          ibus_rdata,
  input  logic           ibus_ack,
  fetch_decode_if.src    fd
);

  typedef enum logic {S_REQ, S_HOLD} state_t;

  state_t state;
  word_t  pc_q;

  assign ibus_stb = ibus_cyc;  // classic, no pipelining
  assign ibus_adr = pc_q;
  assign fd.pc    = pc_q;      // stable while the instruction waits in decode

  always_ff @(posedge clk) begin
    if (rstn) begin
      state    <= S_REQ;
      ibus_cyc <= 1'b0;
      fd.valid <= 1'b0;
      pc_q     <= `RESET_PC;
    end else begin
      case (state)
        S_REQ: begin
          if (!ibus_cyc) begin
            ibus_cyc <= 1'b1;  // only right after reset
          end else if (ibus_ack) begin
            ibus_cyc <= 1'b0;
            fd.instr <= ibus_rdata;
            fd.valid <= 1'b1;
            state    <= S_HOLD;
          end
        end
        S_HOLD: begin
          if (fd.valid && fd.ready)
            fd.valid <= 1'b0;
          // wait for execute to say where to go next
          if (npc_valid) begin
            pc_q     <= npc;
            ibus_cyc <= 1'b1;
            state    <= S_REQ;
          end
        end
        default: state <= S_REQ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- decode_stage.sv
`default_nettype none
`include "core_cfg.svh"

module decode_stage import core_pkg::*; (
  input  wire            clk,
  input  wire            rstn,
  fetch_decode_if.dst    fd,
  decode_exec_if.src     de,
  output reg_idx_t       rs1,
  output reg_idx_t       rs2,
  input  word_t          rs1_data,
  input  word_t          rs2_data,
  output logic [11:0]    csr_raddr,
  input  word_t          csr_rdata
);

  instr_u  ins;
  opcode_t op;
  funct3_t f3;
  word_t   imm;
  word_t   csr_src;
  word_t   csr_new;
  word_t   op_a;
  word_t   op_b;
  alu_op_t op_sel;
  logic    alt;

  assign ins = fd.instr;
  assign op  = ins.r_fmt.opcode;
  assign f3  = ins.r_fmt.funct3;
  assign rs1 = ins.r_fmt.rs1;
  assign rs2 = ins.r_fmt.rs2;

  // ecall reads mtvec, mret reads mepc, so execute sees the jump base as csr_rdata
  assign csr_raddr = (op == OP_SYS && f3 == 3'b000) ?
                     ((ins.i_fmt.imm == 12'h000) ? `CSR_MTVEC : `CSR_MEPC) :
                     ins.i_fmt.imm;

  always_comb begin
    case (op)
      OP_LUI, OP_AUIPC: imm = {ins.u_fmt.imm, 12'b0};
      OP_JAL:    imm = {{12{ins.j_fmt.imm20}}, ins.j_fmt.imm19_12, ins.j_fmt.imm11,
                        ins.j_fmt.imm10_1, 1'b0};
      OP_BRANCH: imm = {{20{ins.b_fmt.imm12}}, ins.b_fmt.imm11, ins.b_fmt.imm10_5,
                        ins.b_fmt.imm4_1, 1'b0};
      OP_STORE:  imm = {{20{ins.s_fmt.imm_hi[6]}}, ins.s_fmt.imm_hi, ins.s_fmt.imm_lo};
      default:   imm = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
    endcase
  end

  // zimm for the immediate CSR forms
  assign csr_src = f3[2] ? {27'b0, ins.i_fmt.rs1} : rs1_data;

  always_comb begin
    case (f3[1:0])
      2'b01:   csr_new = csr_src;               // csrrw
      2'b10:   csr_new = csr_rdata | csr_src;   // csrrs
      2'b11:   csr_new = csr_rdata & ~csr_src;  // csrrc
      default: csr_new = csr_rdata;
    endcase
  end

  // bit 30 picks sub/sra, but addi has no alternate form
  assign alt = ins.r_fmt.funct7[5] && (op == OP_CALRR || f3 == 3'b101);

  always_comb begin
    op_a   = rs1_data;
    op_b   = imm;
    op_sel = ALU_ADD;
    case (op)
      OP_LUI:   op_sel = ALU_PASSB;
      OP_AUIPC: op_a = fd.pc;
      OP_JAL, OP_JALR: begin
        op_a = fd.pc;  // link value
        op_b = 32'd4;
      end
      OP_BRANCH: begin
        op_b = rs2_data;
        case (f3)
          BR_BLT, BR_BGE:   op_sel = ALU_SLT;
          BR_BLTU, BR_BGEU: op_sel = ALU_SLTU;
          default:          op_sel = ALU_SUB;
        endcase
      end
      OP_CALRI, OP_CALRR: begin
        if (op == OP_CALRR)
          op_b = rs2_data;
        case (f3)
          3'b000:  op_sel = alt ? ALU_SUB : ALU_ADD;
          3'b001:  op_sel = ALU_SLL;
          3'b010:  op_sel = ALU_SLT;
          3'b011:  op_sel = ALU_SLTU;
          3'b100:  op_sel = ALU_XOR;
          3'b101:  op_sel = alt ? ALU_SRA : ALU_SRL;
          3'b110:  op_sel = ALU_OR;
          default: op_sel = ALU_AND;
        endcase
      end
      OP_SYS: begin
        op_b   = csr_new;
        op_sel = ALU_PASSB;
      end
      default: ;  // loads and stores add rs1 and imm
    endcase
  end

  assign fd.ready = !de.valid || de.ready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      de.valid <= 1'b0;
    end else if (fd.valid && fd.ready) begin
      de.valid     <= 1'b1;
      de.pc        <= fd.pc;
      de.opcode    <= op;
      de.funct3    <= f3;
      de.rd        <= ins.r_fmt.rd;
      de.src1      <= rs1_data;
      de.src2      <= rs2_data;
      de.imm       <= imm;
      de.csr_rdata <= csr_rdata;
      de.csr_addr  <= ins.i_fmt.imm;
      de.alu_a     <= op_a;
      de.alu_b     <= op_b;
      de.alu_op    <= op_sel;
    end else if (de.ready) begin
      de.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- exec_stage.sv
`default_nettype none
`include "core_cfg.svh"

module exec_stage import core_pkg::*; (
  input  wire           clk,
  input  wire           rstn,
  decode_exec_if.dst    de,
  output logic          npc_valid,
  output word_t         npc,
  output logic          gpr_wen,
  output reg_idx_t      gpr_waddr,
  output word_t         gpr_wdata,
  output logic          csr_wen1,
  output logic [11:0]   csr_waddr1,
  output word_t         csr_wdata1,
  output logic          csr_wen2,
  output logic [11:0]   csr_waddr2,
  output word_t         csr_wdata2,
  output logic          dbus_cyc,
  output logic          dbus_stb,
  output logic          dbus_we,
  output word_t         dbus_adr,
  output logic [3:0]    dbus_sel,
  output word_t         dbus_wdata,
  input  word_t         dbus_rdata,
  input  logic          dbus_ack
);

  word_t    alu_val;
  logic     accept;
  logic     is_mem, is_sys_jump, is_ecall, is_csr;
  logic     br_en;
  logic     wen_d;
  word_t    wdata_d;
  word_t    base, offs, npc_d;
  logic [3:0] sel_d;
  funct3_t  mem_f3;
  reg_idx_t mem_rd;
  logic [1:0] mem_off;
  word_t    ld_shift, ld_val;

  alu u_alu (
    .alu_a  (de.alu_a),
    .alu_b  (de.alu_b),
    .alu_op (de.alu_op),
    .val    (alu_val)
  );

  assign accept      = de.valid && de.ready;
  assign is_mem      = (de.opcode == OP_LOAD) || (de.opcode == OP_STORE);
  assign is_sys_jump = (de.opcode == OP_SYS) && (de.funct3 == 3'b000);  // ecall or mret
  assign is_ecall    = is_sys_jump && (de.csr_addr == 12'h000);
  assign is_csr      = (de.opcode == OP_SYS) && (de.funct3 != 3'b000);

  always_comb begin
    case (de.funct3)
      BR_BEQ:           br_en = (alu_val == '0);
      BR_BNE:           br_en = (alu_val != '0);
      BR_BLT, BR_BLTU:  br_en = alu_val[0];
      BR_BGE, BR_BGEU:  br_en = !alu_val[0];
      default:          br_en = 1'b0;
    endcase
  end

  always_comb begin
    base = de.pc;
    offs = 32'd4;
    case (de.opcode)
      OP_JAL:    offs = de.imm;
      OP_JALR: begin
        base = de.src1;
        offs = de.imm;
      end
      OP_BRANCH: if (br_en) offs = de.imm;
      OP_SYS: begin
        if (is_sys_jump) begin
          base = de.csr_rdata;  // mtvec for ecall, mepc for mret
          offs = '0;
        end
      end
      default: ;
    endcase
  end

  assign npc_d = base + offs;

  // loads write back on ack, not here
  always_comb begin
    wdata_d = alu_val;
    case (de.opcode)
      OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_CALRI, OP_CALRR: wen_d = 1'b1;
      OP_SYS: begin
        wen_d   = is_csr;
        wdata_d = de.csr_rdata;  // old CSR value to rd
      end
      default: wen_d = 1'b0;
    endcase
  end

  always_comb begin
    case (de.funct3[1:0])
      2'b00:   sel_d = 4'b0001 << alu_val[1:0];
      2'b01:   sel_d = 4'b0011 << alu_val[1:0];
      default: sel_d = 4'b1111;
    endcase
  end

  assign ld_shift = dbus_rdata >> {mem_off, 3'b000};

  always_comb begin
    case (mem_f3)
      3'b000:  ld_val = {{24{ld_shift[7]}}, ld_shift[7:0]};     // lb
      3'b001:  ld_val = {{16{ld_shift[15]}}, ld_shift[15:0]};   // lh
      3'b100:  ld_val = {24'b0, ld_shift[7:0]};                 // lbu
      3'b101:  ld_val = {16'b0, ld_shift[15:0]};                // lhu
      default: ld_val = ld_shift;                               // lw
    endcase
  end

  assign dbus_stb = dbus_cyc;

  always_ff @(posedge clk) begin
    if (rstn) begin
      de.ready  <= 1'b1;
      npc_valid <= 1'b0;
      gpr_wen   <= 1'b0;
      csr_wen1  <= 1'b0;
      csr_wen2  <= 1'b0;
      dbus_cyc  <= 1'b0;
      dbus_we   <= 1'b0;
    end else begin
      // write enables and redirect are single-cycle pulses
      npc_valid <= 1'b0;
      gpr_wen   <= 1'b0;
      csr_wen1  <= 1'b0;
      csr_wen2  <= 1'b0;

      if (accept) begin
        npc        <= {npc_d[31:1], 1'b0};
        gpr_waddr  <= de.rd;
        gpr_wdata  <= wdata_d;
        csr_waddr1 <= is_ecall ? `CSR_MEPC : de.csr_addr;
        csr_wdata1 <= is_ecall ? de.pc : alu_val;
        csr_waddr2 <= `CSR_MCAUSE;
        csr_wdata2 <= `CAUSE_ECALL_M;
        if (is_mem) begin
          de.ready   <= 1'b0;  // hold decode until ack
          dbus_cyc   <= 1'b1;
          dbus_we    <= (de.opcode == OP_STORE);
          dbus_adr   <= {alu_val[31:2], 2'b00};
          dbus_sel   <= sel_d;
          dbus_wdata <= de.src2 << {alu_val[1:0], 3'b000};
          mem_f3     <= de.funct3;
          mem_rd     <= de.rd;
          mem_off    <= alu_val[1:0];
        end else begin
          npc_valid <= 1'b1;
          gpr_wen   <= wen_d;
          csr_wen1  <= is_csr || is_ecall;
          csr_wen2  <= is_ecall;
        end
      end

      if (dbus_cyc && dbus_ack) begin
        dbus_cyc  <= 1'b0;
        npc_valid <= 1'b1;
        de.ready  <= 1'b1;
        if (!dbus_we) begin
          gpr_wen   <= 1'b1;
          gpr_waddr <= mem_rd;
          gpr_wdata <= ld_val;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- core_top.sv
`default_nettype none

module core_top import core_pkg::*; (
  input  wire          clk,
  input  wire          rstn,
  output logic         ibus_cyc,
  output logic         ibus_stb,
  output word_t        ibus_adr,
  input  word_t        ibus_rdata,
  input  logic         ibus_ack,
  output logic         dbus_cyc,
  output logic         dbus_stb,
  output logic         dbus_we,
  output word_t        dbus_adr,
  output logic [3:0]   dbus_sel,
  output word_t        dbus_wdata,
  input  word_t        dbus_rdata,
  input  logic         dbus_ack,
  output logic         gpr_wen,
  output reg_idx_t     gpr_waddr,
  output word_t        gpr_wdata
);

  logic        npc_valid;
  word_t       npc;
  reg_idx_t    rs1, rs2;
  word_t       rs1_data, rs2_data;
  logic [11:0] csr_raddr;
  word_t       csr_rdata;
  logic        csr_wen1, csr_wen2;
  logic [11:0] csr_waddr1, csr_waddr2;
  word_t       csr_wdata1, csr_wdata2;

  fetch_decode_if fd_bus ();
  decode_exec_if  de_bus ();

  fetch_stage u_fetch (
    .clk, .rstn, .npc_valid, .npc,
    .ibus_cyc, .ibus_stb, .ibus_adr, .ibus_rdata, .ibus_ack,
    .fd (fd_bus.src)
  );

  decode_stage u_decode (
    .clk, .rstn,
    .fd (fd_bus.dst),
    .de (de_bus.src),
    .rs1, .rs2, .rs1_data, .rs2_data,
    .csr_raddr, .csr_rdata
  );

  exec_stage u_exec (
    .clk, .rstn,
    .de (de_bus.dst),
    .npc_valid, .npc,
    .gpr_wen, .gpr_waddr, .gpr_wdata,
    .csr_wen1, .csr_waddr1, .csr_wdata1,
    .csr_wen2, .csr_waddr2, .csr_wdata2,
    .dbus_cyc, .dbus_stb, .dbus_we, .dbus_adr, .dbus_sel,
    .dbus_wdata, .dbus_rdata, .dbus_ack
  );

  reg_file u_regs (
    .clk, .rs1, .rs2, .rs1_data, .rs2_data,
    .gpr_wen, .gpr_waddr, .gpr_wdata
  );

  csr_file u_csrs (
    .clk, .rstn, .csr_raddr, .csr_rdata,
    .csr_wen1, .csr_waddr1, .csr_wdata1,
    .csr_wen2, .csr_waddr2, .csr_wdata2
  );

endmodule

`default_nettype wire

//--- tb_core.sv
`default_nettype none
`include "core_cfg.svh"

module tb_core import core_pkg::*; ();

  localparam int TIMEOUT = 3000;

  logic       clk;
  logic       rstn;
  logic       ibus_cyc, ibus_stb, ibus_ack;
  word_t      ibus_adr, ibus_rdata;
  logic       dbus_cyc, dbus_stb, dbus_we, dbus_ack;
  word_t      dbus_adr, dbus_wdata, dbus_rdata;
  logic [3:0] dbus_sel;
  logic       gpr_wen;
  reg_idx_t   gpr_waddr;
  word_t      gpr_wdata;

  word_t      imem [0:255];
  word_t      dmem [0:255];
  logic [31:0] lfsr = 32'h959c;
  int         iwait, dwait;
  int         errors, tests, failed_tests;
  word_t      pc_w;
  logic       icyc_seen, dcyc_seen;

  // observed traffic and expected write-backs
  reg_idx_t   wb_addr_q[$], exp_addr_q[$];
  word_t      wb_data_q[$], exp_data_q[$];
  word_t      fetch_q[$], exp_fetch_q[$];
  word_t      db_adr_q[$], db_wdata_q[$];
  logic [3:0] db_sel_q[$];
  logic       db_we_q[$];

  core_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // one LFSR step per bit taken
  function automatic logic [7:0] next_bits(int n);
    logic b;
    next_bits = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b)
        lfsr = lfsr ^ 32'h8020_0003;
      next_bits = {next_bits[6:0], b};
    end
  endfunction

  // memory models for both buses with wait states from the LFSR
  always @(posedge clk) begin
    #1;
    if (ibus_cyc && ibus_stb && !ibus_ack) begin
      if (iwait == 0) begin
        ibus_ack   = 1'b1;
        ibus_rdata = imem[ibus_adr[9:2]];
      end else
        iwait = iwait - 1;
    end else begin
      ibus_ack = 1'b0;
      iwait    = next_bits(2);
    end
    if (dbus_cyc && dbus_stb && !dbus_ack) begin
      if (dwait == 0) begin
        dbus_ack = 1'b1;
        if (dbus_we) begin
          for (int b = 0; b < 4; b++)
            if (dbus_sel[b])
              dmem[dbus_adr[9:2]][8*b +: 8] = dbus_wdata[8*b +: 8];
        end else
          dbus_rdata = dmem[dbus_adr[9:2]];
      end else
        dwait = dwait - 1;
    end else begin
      dbus_ack = 1'b0;
      dwait    = next_bits(2);
    end
  end

  // outputs sampled mid-cycle
  always @(negedge clk) begin
    if (gpr_wen) begin
      wb_addr_q.push_back(gpr_waddr);
      wb_data_q.push_back(gpr_wdata);
    end
    if (ibus_cyc && !icyc_seen)
      fetch_q.push_back(ibus_adr);
    if (dbus_cyc && !dcyc_seen) begin
      db_adr_q.push_back(dbus_adr);
      db_sel_q.push_back(dbus_sel);
      db_wdata_q.push_back(dbus_wdata);
      db_we_q.push_back(dbus_we);
    end
    icyc_seen = ibus_cyc;
    dcyc_seen = dbus_cyc;
  end

  task automatic check_word(string name, word_t exp, word_t act);
    if (exp !== act) begin
      $display("ERR %s: expected %08h, actual %08h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_reg(string name, reg_idx_t exp, reg_idx_t act);
    if (exp !== act) begin
      $display("ERR %s: expected x%0d, actual x%0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_sel(string name, logic [3:0] exp, logic [3:0] act);
    if (exp !== act) begin
      $display("ERR %s: expected sel %b, actual sel %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("ERR %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, funct3_t f3,
                                  reg_idx_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                  funct3_t f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1, funct3_t f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic word_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1, funct3_t f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic word_t enc_j(logic [20:0] imm, reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic word_t addi(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
    return enc_i(imm, rs1, 3'b000, rd, 7'h13);
  endfunction

  function automatic logic taken_ref(funct3_t f3, word_t a, word_t b);
    case (f3)
      BR_BEQ:  return a == b;
      BR_BNE:  return a != b;
      BR_BLT:  return $signed(a) < $signed(b);
      BR_BGE:  return $signed(a) >= $signed(b);
      BR_BLTU: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // fill values never executed or read unwritten
  task automatic clear_mem();
    for (int i = 0; i < 256; i++) begin
      imem[i] = addi(5'd0, 5'd0, 12'(i));
      dmem[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'(i * 3)};
    end
    exp_addr_q.delete();
    exp_data_q.delete();
    exp_fetch_q.delete();
    pc_w = `RESET_PC;
  endtask

  task automatic emit(word_t ins);
    exp_fetch_q.push_back(pc_w);
    imem[pc_w[9:2]] = ins;
    pc_w = pc_w + 4;
  endtask

  task automatic emit_skip(word_t ins);  // placed but never reached
    imem[pc_w[9:2]] = ins;
    pc_w = pc_w + 4;
  endtask

  task automatic expect_wb(reg_idx_t rd, word_t val);
    exp_addr_q.push_back(rd);
    exp_data_q.push_back(val);
  endtask

  task automatic apply_reset(string name);
    rstn = 1'b1;
    repeat (16) begin
      @(posedge clk);
      #1;
      check_bit({name, " ibus_cyc in reset"}, 1'b0, ibus_cyc);
      check_bit({name, " ibus_stb in reset"}, 1'b0, ibus_stb);
      check_bit({name, " dbus_cyc in reset"}, 1'b0, dbus_cyc);
      check_bit({name, " dbus_stb in reset"}, 1'b0, dbus_stb);
      check_bit({name, " gpr_wen in reset"}, 1'b0, gpr_wen);
    end
    wb_addr_q.delete();
    wb_data_q.delete();
    fetch_q.delete();
    db_adr_q.delete();
    db_sel_q.delete();
    db_wdata_q.delete();
    db_we_q.delete();
    rstn = 1'b0;
  endtask

  // kind 0 write-backs, 1 fetches, 2 data-bus cycles
  task automatic wait_for_events(string name, int kind, int n);
    int t;
    int cnt;
    for (t = 0; t < TIMEOUT; t++) begin
      cnt = (kind == 0) ? wb_addr_q.size() : (kind == 1) ? fetch_q.size() : db_adr_q.size();
      if (cnt >= n)
        break;
      @(posedge clk);
      #1;
    end
    if (t == TIMEOUT) begin
      $display("%s: timed out, the core stopped producing bus or write-back activity", name);
      errors++;
    end
  endtask

  task automatic compare_wb(string name);
    wait_for_events(name, 0, exp_addr_q.size());
    for (int i = 0; i < exp_addr_q.size() && i < wb_addr_q.size(); i++) begin
      check_reg($sformatf("%s wb%0d addr", name, i), exp_addr_q[i], wb_addr_q[i]);
      check_word($sformatf("%s wb%0d data", name, i), exp_data_q[i], wb_data_q[i]);
    end
  endtask

  task automatic compare_fetch(string name);
    wait_for_events(name, 1, exp_fetch_q.size());
    for (int i = 0; i < exp_fetch_q.size() && i < fetch_q.size(); i++)
      check_word($sformatf("%s fetch%0d", name, i), exp_fetch_q[i], fetch_q[i]);
  endtask

  task automatic report(string name, int errs_before);
    tests++;
    if (errors == errs_before)
      $display("%s: ok", name);
    else begin
      failed_tests++;
      $display("%s: %0d mismatches", name, errors - errs_before);
    end
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    clear_mem();
    emit(enc_j(21'd0, 5'd0));
    apply_reset("reset");
    wait_for_events("reset", 1, 1);
    if (fetch_q.size() > 0)
      check_word("reset first fetch", `RESET_PC, fetch_q[0]);
    report("reset", e0);
  endtask

  task automatic test_arith();
    int e0;
    word_t a, b;
    e0 = errors;
    a  = 32'd5;
    b  = -32'sd3;
    clear_mem();
    emit(addi(5'd1, 5'd0, 12'd5));
    expect_wb(5'd1, a);
    emit(addi(5'd2, 5'd0, -12'sd3));
    expect_wb(5'd2, b);
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    expect_wb(5'd3, a + b);
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
    expect_wb(5'd4, a - b);
    emit(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd5));
    expect_wb(5'd5, 32'($signed(b) < $signed(a)));
    emit(enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd6));
    expect_wb(5'd6, 32'(b < a));
    emit(enc_i(12'h0f0, 5'd1, 3'b100, 5'd7, 7'h13));
    expect_wb(5'd7, a ^ 32'h0f0);
    emit(enc_i(12'h004, 5'd1, 3'b001, 5'd8, 7'h13));
    expect_wb(5'd8, a << 4);
    emit(enc_i(12'h401, 5'd2, 3'b101, 5'd9, 7'h13));
    expect_wb(5'd9, $signed(b) >>> 1);
    emit(enc_i(12'h01c, 5'd2, 3'b101, 5'd10, 7'h13));
    expect_wb(5'd10, b >> 28);
    emit({20'h12345, 5'd11, 7'h37});
    expect_wb(5'd11, 32'h1234_5000);
    emit({20'h00001, 5'd12, 7'h17});
    expect_wb(5'd12, 32'h1000 + 32'h2c);
    emit(addi(5'd0, 5'd1, 12'd7));
    expect_wb(5'd0, a + 7);
    emit(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd13));
    expect_wb(5'd13, a);  // x0 reads zero
    emit(enc_j(21'd0, 5'd0));
    apply_reset("arith");
    compare_wb("arith");
    report("arith", e0);
  endtask

  task automatic br(funct3_t f3, reg_idx_t ra, reg_idx_t rb, word_t va, word_t vb);
    emit(enc_b(13'd8, rb, ra, f3));
    if (taken_ref(f3, va, vb))
      emit_skip(addi(5'd3, 5'd0, 12'd99));
  endtask

  task automatic test_branch();
    int e0;
    word_t p1, p2;
    word_t one, neg;
    e0  = errors;
    one = 32'd1;
    neg = '1;
    clear_mem();
    emit(addi(5'd1, 5'd0, 12'd1));
    expect_wb(5'd1, one);
    emit(addi(5'd2, 5'd0, 12'hfff));
    expect_wb(5'd2, neg);
    br(BR_BEQ, 5'd1, 5'd1, one, one);
    br(BR_BEQ, 5'd1, 5'd2, one, neg);
    br(BR_BNE, 5'd1, 5'd2, one, neg);
    br(BR_BNE, 5'd1, 5'd1, one, one);
    br(BR_BLT, 5'd2, 5'd1, neg, one);
    br(BR_BLT, 5'd1, 5'd2, one, neg);
    br(BR_BGE, 5'd1, 5'd2, one, neg);
    br(BR_BGE, 5'd2, 5'd1, neg, one);
    br(BR_BLTU, 5'd1, 5'd2, one, neg);
    br(BR_BLTU, 5'd2, 5'd1, neg, one);
    br(BR_BGEU, 5'd2, 5'd1, neg, one);
    br(BR_BGEU, 5'd1, 5'd2, one, neg);
    p1 = pc_w;
    emit(enc_j(21'd8, 5'd4));
    expect_wb(5'd4, p1 + 4);
    emit_skip(addi(5'd3, 5'd0, 12'd99));
    p2 = pc_w;
    // odd target whose bit 0 must be cleared
    emit(enc_i(12'(p2 + 8), 5'd1, 3'b000, 5'd5, 7'h67));
    expect_wb(5'd5, p2 + 4);
    emit_skip(addi(5'd3, 5'd0, 12'd99));
    emit(enc_j(21'd0, 5'd0));
    apply_reset("branch");
    compare_wb("branch");
    compare_fetch("branch");
    report("branch", e0);
  endtask

  task automatic test_mem();
    int e0;
    word_t v;
    e0 = errors;
    v  = (32'h89abd << 12) + 32'hffff_fdef;
    clear_mem();
    emit(addi(5'd1, 5'd0, 12'h080));
    expect_wb(5'd1, 32'h80);
    emit({20'h89abd, 5'd2, 7'h37});
    expect_wb(5'd2, 32'h89abd000);
    emit(addi(5'd2, 5'd2, 12'hdef));
    expect_wb(5'd2, v);
    emit(enc_s(12'd0, 5'd2, 5'd1, 3'b010));
    emit(enc_s(12'd5, 5'd2, 5'd1, 3'b000));
    emit(enc_s(12'd10, 5'd2, 5'd1, 3'b001));
    emit(enc_i(12'd0, 5'd1, 3'b010, 5'd3, 7'h03));
    expect_wb(5'd3, v);
    emit(enc_i(12'd0, 5'd1, 3'b000, 5'd4, 7'h03));
    expect_wb(5'd4, {{24{v[7]}}, v[7:0]});
    emit(enc_i(12'd0, 5'd1, 3'b100, 5'd5, 7'h03));
    expect_wb(5'd5, {24'b0, v[7:0]});
    emit(enc_i(12'd2, 5'd1, 3'b001, 5'd6, 7'h03));
    expect_wb(5'd6, {{16{v[31]}}, v[31:16]});
    emit(enc_i(12'd2, 5'd1, 3'b101, 5'd7, 7'h03));
    expect_wb(5'd7, {16'b0, v[31:16]});
    emit(enc_i(12'd5, 5'd1, 3'b000, 5'd8, 7'h03));
    expect_wb(5'd8, {{24{v[7]}}, v[7:0]});
    emit(enc_i(12'd10, 5'd1, 3'b101, 5'd9, 7'h03));
    expect_wb(5'd9, {16'b0, v[15:0]});
    emit(enc_j(21'd0, 5'd0));
    apply_reset("mem");
    compare_wb("mem");
    wait_for_events("mem", 2, 4);
    if (db_adr_q.size() >= 4) begin
      check_bit("mem sw we", 1'b1, db_we_q[0]);
      check_word("mem sw adr", 32'h80, db_adr_q[0]);
      check_sel("mem sw sel", 4'b1111, db_sel_q[0]);
      check_word("mem sw data", v, db_wdata_q[0]);
      check_word("mem sb adr", 32'h84, db_adr_q[1]);
      check_sel("mem sb sel", 4'b0010, db_sel_q[1]);
      check_word("mem sb data", v << 8, db_wdata_q[1]);
      check_word("mem sh adr", 32'h88, db_adr_q[2]);
      check_sel("mem sh sel", 4'b1100, db_sel_q[2]);
      check_word("mem sh data", v << 16, db_wdata_q[2]);
      check_bit("mem lw we", 1'b0, db_we_q[3]);
    end
    report("mem", e0);
  endtask

  task automatic test_csr();
    int e0;
    e0 = errors;
    clear_mem();
    emit(addi(5'd1, 5'd0, 12'h055));
    expect_wb(5'd1, 32'h55);
    emit(enc_i(`CSR_MSCRATCH, 5'd1, 3'b001, 5'd2, 7'h73));
    expect_wb(5'd2, 32'h0);
    emit(enc_i(`CSR_MSCRATCH, 5'd2, 3'b110, 5'd3, 7'h73));
    expect_wb(5'd3, 32'h55);
    emit(enc_i(`CSR_MSCRATCH, 5'd1, 3'b011, 5'd5, 7'h73));
    expect_wb(5'd5, 32'h57);
    emit(enc_i(`CSR_MSCRATCH, 5'd0, 3'b010, 5'd6, 7'h73));
    expect_wb(5'd6, 32'h57 & ~32'h55);
    emit(32'h0000_0073);  // ecall at 0x14
    pc_w = 32'h100;       // mtvec after reset
    emit(enc_i(`CSR_MCAUSE, 5'd0, 3'b010, 5'd7, 7'h73));
    expect_wb(5'd7, `CAUSE_ECALL_M);
    emit(enc_i(`CSR_MEPC, 5'd0, 3'b010, 5'd8, 7'h73));
    expect_wb(5'd8, 32'h14);
    emit(addi(5'd8, 5'd8, 12'd4));
    expect_wb(5'd8, 32'h18);
    emit(enc_i(`CSR_MEPC, 5'd8, 3'b001, 5'd0, 7'h73));
    expect_wb(5'd0, 32'h14);
    emit(32'h3020_0073);  // mret
    pc_w = 32'h18;
    emit(addi(5'd9, 5'd0, 12'd7));
    expect_wb(5'd9, 32'd7);
    emit(enc_j(21'd0, 5'd0));
    apply_reset("csr");
    compare_wb("csr");
    compare_fetch("csr");
    report("csr", e0);
  endtask

  initial begin
    rstn         = 1'b1;
    ibus_ack     = 1'b0;
    ibus_rdata   = '0;
    dbus_ack     = 1'b0;
    dbus_rdata   = '0;
    iwait        = 0;
    dwait        = 0;
    icyc_seen    = 1'b0;
    dcyc_seen    = 1'b0;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    test_reset();
    test_arith();
    test_branch();
    test_mem();
    test_csr();
    $display("%0d tests run, %0d failed, %0d mismatches", tests, failed_tests, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
core_pkg.sv
stage_if.sv
alu.sv
reg_file.sv
csr_file.sv
fetch_stage.sv
decode_stage.sv
exec_stage.sv
core_top.sv
tb_core.sv
